/* dv/pipe_trace.txt */
// cnt(dec) mode ctrl ltssm_state power_req rx_status rx_data rx_datak link_data link_datak
// levels, then ts1 ts2 ack looking detected skp cycle counts (dec)
4 0 020 00 2 0 00000000 0 00000000 0 208 0 0 0 0 0 0
2 0 021 00 2 0 00000000 0 00000000 0 208 0 0 0 0 0 0
4 0 020 00 2 0 00000000 0 00000000 0 209 0 0 0 0 0 0
6 0 060 00 2 0 00000000 0 00000000 0 209 0 0 2 0 0 0
40 0 0a0 00 2 0 00000000 0 00000000 0 239 0 0 0 40 0 0
8 0 021 00 2 3 00000000 0 00000000 0 209 0 0 0 0 3 0
40 0 0a0 00 2 0 00000000 0 00000000 0 239 0 0 0 40 0 0
8 0 021 00 2 5 00000000 0 00000000 0 209 0 0 0 0 0 0
4 0 060 00 0 0 00000000 0 00000000 0 001 0 0 0 0 0 0
4 0 061 00 0 0 00000000 0 00000000 0 001 0 0 2 0 0 0
16 0 0a0 00 0 0 00000000 0 00000000 0 001 0 0 0 3 8 0
8 2 020 00 0 0 00000000 0 00000000 0 001 2 0 0 0 0 0
8 3 020 00 0 0 00000000 0 00000000 0 001 0 2 0 0 0 0
8 4 020 00 0 0 00000000 0 00000000 0 001 0 0 0 0 0 0
8 5 020 00 0 0 00000000 0 00000000 0 001 0 0 0 0 0 0
120 1 026 00 0 0 00000000 0 00000000 0 001 0 0 0 0 0 0
160 1 02e 00 0 0 00000000 0 00000000 0 001 0 0 0 0 0 1
20 0 23e 00 0 0 00000000 0 00000000 0 003 0 0 0 0 0 0
6 0 122 10 0 0 00000000 0 11223344 0 005 0 0 0 0 0 0
3 0 022 10 0 0 00000000 0 00000000 0 005 0 0 0 0 0 0
4 0 122 10 0 0 00000000 0 cafef00d 1 005 0 0 0 0 0 0
2 0 020 00 0 0 00000000 0 00000000 0 001 0 0 0 0 0 0

/* src.f */
design/pipe_pkg.sv
design/pipe_link_ctrl.sv
design/rx_ordered_set_detect.sv
design/phy_power_ctrl.sv
design/rx_detect.sv
design/usb3_pipe_top.sv
dv/pipe_monitor.sv
dv/pipe_chk.sv
dv/tb_usb3_pipe.sv

/* Bender.yml */
package:
  name: usb3_pipe

sources:
  - design/pipe_pkg.sv
  - design/pipe_link_ctrl.sv
  - design/rx_ordered_set_detect.sv
  - design/phy_power_ctrl.sv
  - design/rx_detect.sv
  - design/usb3_pipe_top.sv
  - target: simulation
    files:
      - dv/pipe_monitor.sv
      - dv/pipe_chk.sv
      - dv/tb_usb3_pipe.sv

/* dv/tb_usb3_pipe.sv */
////////////////////
// testbench top for the usb3 pipe control layer
// clock, reset, trace reader, stimulus driver,
// watchdog and final report
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_usb3_pipe
	import pipe_pkg::*;
();

	// one trace record, inputs held for cnt cycles
	typedef struct {
		int          cnt;
		logic [3:0]  mode;
		logic [11:0] ctrl;
		lt_state_t   state;
		pwr_state_t  preq;
		logic [2:0]  rxst;
		pipe_word_t  rxd;
		pipe_kmask_t rxk;
		pipe_word_t  lod;
		pipe_kmask_t lok;
		logic [11:0] lvl;
		int          ts1, ts2, ack, look, det, skp;
	} record_t;

	logic        local_clk;
	logic        ltssm_hot_reset_active;
	logic        phy_status;
	pipe_word_t  phy_rx_data;
	pipe_kmask_t phy_rx_datak;
	logic        phy_rx_valid;
	logic [2:0]  phy_rx_status;
	pipe_word_t  phy_tx_data;
	pipe_kmask_t phy_tx_datak;
	logic        phy_tx_elecidle;
	logic        phy_tx_detrx_lpbk;
	pwr_state_t  phy_power_down;
	lt_state_t   ltssm_state;
	logic        ltssm_training;
	logic        ltssm_train_active;
	logic        ltssm_train_config;
	logic        ltssm_train_idle;
	logic        ltssm_tx_elecidle;
	logic        ltssm_tx_detrx_lpbk;
	logic        ltssm_power_go;
	pwr_state_t  ltssm_power_down;
	logic        partner_detect;
	logic        ltssm_reset_n;
	logic        ltssm_train_idle_pass;
	logic        ltssm_train_ts1;
	logic        ltssm_train_ts2;
	logic        ltssm_power_ack;
	logic        partner_looking;
	logic        partner_detected;
	pipe_word_t  link_out_data;
	pipe_kmask_t link_out_datak;
	logic        link_out_valid;
	logic        link_out_ready;
	pipe_word_t  link_in_data;
	pipe_kmask_t link_in_datak;
	logic        link_in_valid;

	// expectations handed to the monitor
	int          rec_id;
	logic [3:0]  rec_mode;
	logic [11:0] rec_lvl;
	int          exp_ts1, exp_ts2, exp_ack, exp_look, exp_det, exp_skp;

	record_t     trace_q [$];
	int          limit_cycles = 0;

	usb3_pipe_top usb3_pipe_top_inst (.*);

	pipe_monitor monitor_inst (.*);

	initial begin
		local_clk = 1'b0;
		forever #2 local_clk = ~local_clk;
	end

	// words of an injected ordered set, modes 4 and 5 are broken sets
	task automatic os_word(input logic [3:0] mode, input int k,
			output pipe_word_t d, output pipe_kmask_t m);
		m = 4'b0000;
		case (k)
			0: begin
				d = COM_WORD;
				m = (mode == 4'd5) ? 4'b0111 : 4'b1111;
			end
			1: d = (mode == 4'd3) ? TS2_HDR_WORD : TS1_HDR_WORD;
			2: d = (mode == 4'd3) ? TS2_ID_WORD : TS1_ID_WORD;
			default: d = (mode == 4'd3 || mode == 4'd4) ? TS2_ID_WORD : TS1_ID_WORD;
		endcase
	endtask

	task automatic drive_record(input record_t r, input int k);
		pipe_word_t  d;
		pipe_kmask_t m;
		phy_status          = r.ctrl[0];
		ltssm_training      = r.ctrl[1];
		ltssm_train_active  = r.ctrl[2];
		ltssm_train_config  = r.ctrl[3];
		ltssm_train_idle    = r.ctrl[4];
		ltssm_tx_elecidle   = r.ctrl[5];
		ltssm_power_go      = r.ctrl[6];
		partner_detect      = r.ctrl[7];
		link_out_valid      = r.ctrl[8];
		phy_rx_valid        = r.ctrl[9];
		ltssm_tx_detrx_lpbk = r.ctrl[10];
		ltssm_state         = r.state;
		ltssm_power_down    = r.preq;
		phy_rx_status       = r.rxst;
		phy_rx_data         = r.rxd;
		phy_rx_datak        = r.rxk;
		link_out_data       = r.lod;
		link_out_datak      = r.lok;
		if (r.mode >= 4'd2 && r.mode <= 4'd5) begin
			phy_rx_valid = (k < OS_WORDS);
			if (k < OS_WORDS) begin
				os_word(r.mode, k, d, m);
				phy_rx_data  = d;
				phy_rx_datak = m;
			end
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          total;
		int          all_errs;
		string       line;
		logic [31:0] f [17];
		record_t     r;
		ltssm_hot_reset_active = 1'b1;
		r = '{default: 0};
		r.ctrl = 12'h020;
		drive_record(r, 0);
		rec_id = 0;
		rec_mode = '0;
		rec_lvl = '0;
		{exp_ts1, exp_ts2, exp_ack, exp_look, exp_det, exp_skp} = '0;
		total = 0;
		fd = $fopen("dv/pipe_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file dv/pipe_trace.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			while ($fgets(line, fd)) begin
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %d %d %d %d %d %d",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
				if (n == 17) begin
					r = '{f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
						f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]};
					trace_q.push_back(r);
					total += r.cnt;
				end
			end
			$fclose(fd);
			limit_cycles = total + 8 + 100;
			repeat (8) @(posedge local_clk);
			foreach (trace_q[i]) begin
				for (int k = 0; k < trace_q[i].cnt; k++) begin
					@(negedge local_clk);
					ltssm_hot_reset_active = 1'b0;
					rec_id   = i + 1;
					rec_mode = trace_q[i].mode;
					rec_lvl  = trace_q[i].lvl;
					exp_ts1  = trace_q[i].ts1;
					exp_ts2  = trace_q[i].ts2;
					exp_ack  = trace_q[i].ack;
					exp_look = trace_q[i].look;
					exp_det  = trace_q[i].det;
					exp_skp  = trace_q[i].skp;
					drive_record(trace_q[i], k);
				end
			end
			// close the last record so its counts and levels are compared
			@(negedge local_clk);
			rec_id = 0;
			repeat (2) @(posedge local_clk);
			all_errs = monitor_inst.value_errs + monitor_inst.event_errs
				+ usb3_pipe_top_inst.pipe_chk_inst.assert_errs;
			$display("error counts: %0d value, %0d event, %0d assertion",
				monitor_inst.value_errs, monitor_inst.event_errs,
				usb3_pipe_top_inst.pipe_chk_inst.assert_errs);
			if (all_errs == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

	// watchdog, armed once the trace length is known
	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * 4);
		$display("watchdog expired after %0d cycles, the trace did not finish", limit_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/pipe_chk.sv */
////////////////////
// concurrent assertions on the control outputs
// bound into the pipe top level
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_chk
	import pipe_pkg::*;
(
	input logic      local_clk,
	input logic      ltssm_hot_reset_active,
	input lt_state_t ltssm_state,
	input logic      ltssm_train_idle,
	input logic      link_out_ready,
	input logic      ltssm_train_idle_pass,
	input logic      ltssm_power_ack
);

	int assert_errs = 0;

	// ready drops in the cycle after the ltssm leaves U0
	a_ready_in_u0: assert property (@(posedge local_clk) disable iff (ltssm_hot_reset_active)
		link_out_ready && ltssm_state != LT_U0 |=> !link_out_ready)
		else begin
			$error("link_out_ready still high after the ltssm left U0");
			assert_errs++;
		end

	// idle pass hands over to U0 once the idle request drops
	a_pass_to_u0: assert property (@(posedge local_clk) disable iff (ltssm_hot_reset_active)
		ltssm_train_idle_pass && !ltssm_train_idle |=> link_out_ready && !ltssm_train_idle_pass)
		else begin
			$error("idle pass did not hand over to U0");
			assert_errs++;
		end

	// ack pulse is two cycles at most
	a_ack_len: assert property (@(posedge local_clk) disable iff (ltssm_hot_reset_active)
		ltssm_power_ack && $past(ltssm_power_ack) |=> !ltssm_power_ack)
		else begin
			$error("ltssm_power_ack longer than two cycles");
			assert_errs++;
		end

endmodule

bind usb3_pipe_top pipe_chk pipe_chk_inst (
	.local_clk              (local_clk),
	.ltssm_hot_reset_active (ltssm_hot_reset_active),
	.ltssm_state            (ltssm_state),
	.ltssm_train_idle       (ltssm_train_idle),
	.link_out_ready         (link_out_ready),
	.ltssm_train_idle_pass  (ltssm_train_idle_pass),
	.ltssm_power_ack        (ltssm_power_ack)
);

`default_nettype wire

/* dv/pipe_monitor.sv */
////////////////////
// checking module for the pipe control layer
// per-record counts and levels, training stream model,
// U0 pass-through and receive register checks
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_monitor
	import pipe_pkg::*;
(
	input  logic        local_clk,
	input  int          rec_id,
	input  logic [3:0]  rec_mode,
	input  logic [11:0] rec_lvl,
	input  int          exp_ts1, exp_ts2, exp_ack, exp_look, exp_det, exp_skp,
	input  logic        ltssm_reset_n,
	input  logic        ltssm_train_idle_pass,
	input  logic        link_out_ready,
	input  logic        phy_tx_elecidle,
	input  logic        phy_tx_detrx_lpbk,
	input  logic        partner_looking,
	input  logic        partner_detected,
	input  pwr_state_t  phy_power_down,
	input  logic        ltssm_train_ts1,
	input  logic        ltssm_train_ts2,
	input  logic        ltssm_power_ack,
	input  pipe_word_t  phy_tx_data,
	input  pipe_kmask_t phy_tx_datak,
	input  pipe_word_t  link_in_data,
	input  pipe_kmask_t link_in_datak,
	input  logic        link_in_valid,
	input  pipe_word_t  phy_rx_data,
	input  pipe_kmask_t phy_rx_datak,
	input  logic        phy_rx_valid,
	input  logic        ltssm_train_config,
	input  pipe_word_t  link_out_data,
	input  pipe_kmask_t link_out_datak,
	input  logic        link_out_valid
);

	int value_errs = 0;
	int event_errs = 0;

	// record seen at the previous edge and its expectations
	int          prev_id = 0;
	logic [3:0]  p_mode = '0;
	logic [11:0] p_lvl;
	int          p_ts1, p_ts2, p_ack, p_look, p_det, p_skp;
	int          n_ts1, n_ts2, n_ack, n_look, n_det, n_skp, n_words;

	// training stream model
	logic started = 1'b0;
	int   pw;
	logic set_is_ts2;
	int   p_cnt;

	// inputs and outputs from the previous edge
	logic        cfg_q;
	logic        rx_v_q;
	pipe_word_t  rx_d_q;
	pipe_kmask_t rx_k_q;
	logic        rdy_q = 1'b0;
	logic        xfer_q;
	pipe_word_t  lo_d_q;
	pipe_kmask_t lo_k_q;

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, got %h in record %0d", name, exp, act, prev_id);
			value_errs++;
		end
	endtask

	function automatic logic [35:0] expected_word(input int idx, input logic ts2);
		case (idx)
			0: return {4'b1111, COM_WORD};
			1: return {4'b0000, ts2 ? TS2_HDR_WORD : TS1_HDR_WORD};
			4: return {4'b1111, SKP_WORD};
			default: return {4'b0000, ts2 ? TS2_ID_WORD : TS1_ID_WORD};
		endcase
	endfunction

	task automatic check_stream();
		logic [35:0] ew;
		int          pre;
		if (!started) begin
			// the first COM opens the first TS1 set
			if (phy_tx_data == COM_WORD && phy_tx_datak == 4'b1111) begin
				started    = 1'b1;
				pw         = 1;
				set_is_ts2 = 1'b0;
				p_cnt      = 0;
				n_words++;
			end
		end else begin
			ew = expected_word(pw, set_is_ts2);
			compare_value("phy_tx_data", ew[31:0], phy_tx_data);
			compare_value("phy_tx_datak", ew[35:32], phy_tx_datak);
			n_words++;
			if (pw == 4) begin
				n_skp++;
				p_cnt -= SKP_CREDIT;
				pw = 0;
			end else if (pw == OS_WORDS - 1) begin
				pre        = p_cnt;
				p_cnt     += SKP_SYM_PER_OS;
				set_is_ts2 = cfg_q;
				pw         = (pre >= SKP_THRESHOLD) ? 4 : 0;
			end else begin
				pw++;
			end
		end
	endtask

	task automatic finish_record();
		compare_value("ltssm_train_ts1 cycles", p_ts1, n_ts1);
		compare_value("ltssm_train_ts2 cycles", p_ts2, n_ts2);
		compare_value("ltssm_power_ack cycles", p_ack, n_ack);
		compare_value("partner_looking cycles", p_look, n_look);
		compare_value("partner_detected cycles", p_det, n_det);
		compare_value("skp words", p_skp, n_skp);
		compare_value("ltssm_reset_n", p_lvl[0], ltssm_reset_n);
		compare_value("ltssm_train_idle_pass", p_lvl[1], ltssm_train_idle_pass);
		compare_value("link_out_ready", p_lvl[2], link_out_ready);
		compare_value("phy_tx_elecidle", p_lvl[3], phy_tx_elecidle);
		compare_value("phy_tx_detrx_lpbk", p_lvl[4], phy_tx_detrx_lpbk);
		compare_value("partner_looking", p_lvl[5], partner_looking);
		compare_value("partner_detected", p_lvl[6], partner_detected);
		compare_value("phy_power_down", p_lvl[9:8], phy_power_down);
		if (p_mode == 4'd1 && n_words == 0) begin
			$display("no training ordered sets appeared on phy_tx in record %0d", prev_id);
			event_errs++;
		end
	endtask

	// a sample at an edge belongs to the record of the edge before
	always @(posedge local_clk) begin
		if (prev_id != 0) begin
			n_ts1  += ltssm_train_ts1;
			n_ts2  += ltssm_train_ts2;
			n_ack  += ltssm_power_ack;
			n_look += partner_looking;
			n_det  += partner_detected;
			if (p_mode == 4'd1) check_stream();
			if (rdy_q) begin
				compare_value("phy_tx_data", xfer_q ? lo_d_q : IDLE_WORD, phy_tx_data);
				compare_value("phy_tx_datak", xfer_q ? lo_k_q : 4'b0000, phy_tx_datak);
			end
			compare_value("link_in_valid", rx_v_q, link_in_valid);
			if (rx_v_q) begin
				compare_value("link_in_data", rx_d_q, link_in_data);
				compare_value("link_in_datak", rx_k_q, link_in_datak);
			end
		end
		if (rec_id != prev_id) begin
			if (prev_id != 0) finish_record();
			if (rec_mode != 4'd1) started = 1'b0;
			p_mode  = rec_mode;
			p_lvl   = rec_lvl;
			p_ts1   = exp_ts1;
			p_ts2   = exp_ts2;
			p_ack   = exp_ack;
			p_look  = exp_look;
			p_det   = exp_det;
			p_skp   = exp_skp;
			{n_ts1, n_ts2, n_ack, n_look, n_det, n_skp, n_words} = '0;
			prev_id = rec_id;
		end
		cfg_q  = ltssm_train_config;
		rx_v_q = phy_rx_valid;
		rx_d_q = phy_rx_data;
		rx_k_q = phy_rx_datak;
		rdy_q  = link_out_ready;
		xfer_q = link_out_ready && link_out_valid;
		lo_d_q = link_out_data;
		lo_k_q = link_out_datak;
	end

endmodule

`default_nettype wire

/* design/usb3_pipe_top.sv */
////////////////////
// usb3 pipe control layer top
// link control, rx detection, power and rxdet blocks
////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb3_pipe_top
	import pipe_pkg::*;
(
	input  logic        local_clk,
	input  logic        ltssm_hot_reset_active,

	// phy side
	input  logic        phy_status,
	input  pipe_word_t  phy_rx_data,
	input  pipe_kmask_t phy_rx_datak,
	input  logic        phy_rx_valid,
	input  logic [2:0]  phy_rx_status,
	output pipe_word_t  phy_tx_data,
	output pipe_kmask_t phy_tx_datak,
	output logic        phy_tx_elecidle,
	output logic        phy_tx_detrx_lpbk,
	output pwr_state_t  phy_power_down,

	// ltssm side
	input  lt_state_t   ltssm_state,
	input  logic        ltssm_training,
	input  logic        ltssm_train_active,
	input  logic        ltssm_train_config,
	input  logic        ltssm_train_idle,
	input  logic        ltssm_tx_elecidle,
	input  logic        ltssm_tx_detrx_lpbk,
	input  logic        ltssm_power_go,
	input  pwr_state_t  ltssm_power_down,
	input  logic        partner_detect,
	output logic        ltssm_reset_n,
	output logic        ltssm_train_idle_pass,
	output logic        ltssm_train_ts1,
	output logic        ltssm_train_ts2,
	output logic        ltssm_power_ack,
	output logic        partner_looking,
	output logic        partner_detected,

	// link layer side
	input  pipe_word_t  link_out_data,
	input  pipe_kmask_t link_out_datak,
	input  logic        link_out_valid,
	output logic        link_out_ready,
	output pipe_word_t  link_in_data,
	output pipe_kmask_t link_in_datak,
	output logic        link_in_valid
);

	// received idle, from the detector to the link fsm
	logic idle_seen;

	pipe_link_ctrl pipe_link_ctrl_inst (.*);

	rx_ordered_set_detect rx_ordered_set_detect_inst (.*);

	phy_power_ctrl phy_power_ctrl_inst (.*);

	rx_detect rx_detect_inst (.*);

endmodule

`default_nettype wire

/* design/rx_detect.sv */
////////////////////
// receiver detection for the ltssm
// faked in P0/P1, phy detect with timeout otherwise
////////////////////

`timescale 1ns/1ps
`default_nettype none

module rx_detect
	import pipe_pkg::*;
(
	input  logic       local_clk,
	input  logic       ltssm_hot_reset_active,
	input  logic       partner_detect,
	input  pwr_state_t phy_power_down,
	input  logic       phy_status,
	input  logic [2:0] phy_rx_status,
	input  logic       ltssm_tx_detrx_lpbk,
	output logic       partner_looking,
	output logic       partner_detected,
	output logic       phy_tx_detrx_lpbk
);

	typedef enum logic [2:0] {RD_IDLE, RD_FAKE, RD_DELAY, RD_DET, RD_HOLD} rd_state_t;

	rd_state_t   rd_state;
	logic        det_q;
	logic        det_rise;
	logic [5:0]  step_cnt;
	logic [20:0] tmo_cnt;
	logic        detrx_local;

	assign det_rise          = partner_detect && !det_q;
	assign phy_tx_detrx_lpbk = detrx_local | ltssm_tx_detrx_lpbk;

	always_ff @(posedge local_clk) begin
		if (ltssm_hot_reset_active) begin
			rd_state         <= RD_IDLE;
			det_q            <= 1'b0;
			step_cnt         <= '0;
			tmo_cnt          <= '0;
			detrx_local      <= 1'b0;
			partner_looking  <= 1'b0;
			partner_detected <= 1'b0;
		end else begin
			det_q    <= partner_detect;
			step_cnt <= step_cnt + 6'd1;
			tmo_cnt  <= tmo_cnt + 21'd1;
			case (rd_state)
				RD_IDLE: begin
					partner_looking  <= 1'b0;
					partner_detected <= 1'b0;
					if (det_rise) begin
						step_cnt        <= '0;
						tmo_cnt         <= '0;
						partner_looking <= 1'b1;
						// link already up in P0/P1, so report a partner
						rd_state <= (phy_power_down == P0 || phy_power_down == P1) ? RD_FAKE : RD_DELAY;
					end
				end
				RD_FAKE: begin
					partner_looking  <= step_cnt < 6'(RXDET_FAKE_LOOK - 1);
					partner_detected <= step_cnt >= 6'(RXDET_FAKE_LOOK - 1);
					if (step_cnt == 6'(RXDET_FAKE_LOOK + RXDET_FAKE_HOLD - 2)) rd_state <= RD_IDLE;
				end
				RD_DELAY: begin
					if (step_cnt == 6'(RXDET_DELAY - 1)) begin
						detrx_local <= 1'b1;
						rd_state    <= RD_DET;
					end
				end
				RD_DET: begin
					if (phy_status) begin
						partner_looking  <= 1'b0;
						detrx_local      <= 1'b0;
						partner_detected <= (phy_rx_status == RX_STATUS_DETECTED);
						step_cnt         <= '0;
						rd_state         <= RD_HOLD;
					end else if (tmo_cnt == 21'(RXDET_TIMEOUT - 1)) begin
						// no answer from the phy, give up without a result
						partner_looking <= 1'b0;
						detrx_local     <= 1'b0;
						rd_state        <= RD_IDLE;
					end
				end
				RD_HOLD: if (step_cnt == 6'(RXDET_RESULT_HOLD - 2)) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/phy_power_ctrl.sv */
////////////////////
// phy power-down request handling
// and acknowledge back to the ltssm
////////////////////

`timescale 1ns/1ps
`default_nettype none

module phy_power_ctrl
	import pipe_pkg::*;
(
	input  logic       local_clk,
	input  logic       ltssm_hot_reset_active,
	input  logic       ltssm_power_go,
	input  pwr_state_t ltssm_power_down,
	input  logic       phy_status,
	output pwr_state_t phy_power_down,
	output logic       ltssm_power_ack
);

	typedef enum logic [1:0] {PD_IDLE, PD_WAIT, PD_ACK_0, PD_ACK_1} pd_state_t;

	pd_state_t  pd_state;
	logic       go_q;
	logic       go_rise;
	// request captured on the go edge
	pwr_state_t req_q;

	assign go_rise = ltssm_power_go && !go_q;

	always_ff @(posedge local_clk) begin
		if (go_rise) req_q <= ltssm_power_down;
	end

	always_ff @(posedge local_clk) begin
		if (ltssm_hot_reset_active) begin
			pd_state        <= PD_IDLE;
			go_q            <= 1'b0;
			phy_power_down  <= P2;
			ltssm_power_ack <= 1'b0;
		end else begin
			go_q            <= ltssm_power_go;
			ltssm_power_ack <= 1'b0;
			case (pd_state)
				PD_IDLE: begin
					// already there, just acknowledge
					if (go_rise) pd_state <= (ltssm_power_down == phy_power_down) ? PD_ACK_0 : PD_WAIT;
				end
				PD_WAIT: begin
					phy_power_down <= req_q;
					// phy confirms the change with a status pulse
					if (phy_status) begin
						ltssm_power_ack <= 1'b1;
						pd_state        <= PD_ACK_1;
					end
				end
				PD_ACK_0: begin
					ltssm_power_ack <= 1'b1;
					pd_state        <= PD_ACK_1;
				end
				PD_ACK_1: begin
					ltssm_power_ack <= 1'b1;
					pd_state        <= PD_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/rx_ordered_set_detect.sv */
////////////////////
// receive register toward the link layer
// TS1/TS2 ordered-set detection and idle detection
////////////////////

`timescale 1ns/1ps
`default_nettype none

module rx_ordered_set_detect
	import pipe_pkg::*;
(
	input  logic        local_clk,
	input  logic        ltssm_hot_reset_active,
	input  pipe_word_t  phy_rx_data,
	input  pipe_kmask_t phy_rx_datak,
	input  logic        phy_rx_valid,
	input  pwr_state_t  phy_power_down,
	output pipe_word_t  link_in_data,
	output pipe_kmask_t link_in_datak,
	output logic        link_in_valid,
	output logic        ltssm_train_ts1,
	output logic        ltssm_train_ts2,
	output logic        idle_seen
);

	typedef enum logic [1:0] {IDLE, HDR, BODY_0, BODY_1} os_state_t;

	os_state_t os_state;
	// header announced a TS2
	logic      kind_ts2;
	logic      ts1_found;
	logic      ts1_found_q;
	logic      ts2_found;
	logic      ts2_found_q;
	logic      is_com;
	logic      is_body;

	always_ff @(posedge local_clk) begin
		link_in_data  <= phy_rx_data;
		link_in_datak <= phy_rx_datak;
	end

	always_ff @(posedge local_clk) begin
		if (ltssm_hot_reset_active) link_in_valid <= 1'b0;
		else link_in_valid <= phy_rx_valid;
	end

	assign is_com    = (link_in_datak == 4'b1111) && (link_in_data == COM_WORD);
	assign is_body   = (link_in_datak == 4'b0000) &&
	                   (link_in_data == (kind_ts2 ? TS2_ID_WORD : TS1_ID_WORD));
	assign idle_seen = link_in_valid && (link_in_datak == 4'b0000) && (link_in_data == IDLE_WORD);

	// each found pulse is stretched to two cycles
	assign ltssm_train_ts1 = ts1_found | ts1_found_q;
	assign ltssm_train_ts2 = ts2_found | ts2_found_q;

	always_ff @(posedge local_clk) begin
		if (ltssm_hot_reset_active) begin
			os_state    <= IDLE;
			ts1_found   <= 1'b0;
			ts1_found_q <= 1'b0;
			ts2_found   <= 1'b0;
			ts2_found_q <= 1'b0;
		end else begin
			ts1_found   <= 1'b0;
			ts2_found   <= 1'b0;
			ts1_found_q <= ts1_found;
			ts2_found_q <= ts2_found;
			if (phy_power_down != P0) begin
				os_state <= IDLE;
			end else if (link_in_valid) begin
				case (os_state)
					IDLE: if (is_com) os_state <= HDR;
					HDR: begin
						if (link_in_datak == 4'b0000 && link_in_data == TS1_HDR_WORD) begin
							kind_ts2 <= 1'b0;
							os_state <= BODY_0;
						end else if (link_in_datak == 4'b0000 && link_in_data == TS2_HDR_WORD) begin
							kind_ts2 <= 1'b1;
							os_state <= BODY_0;
						end else begin
							os_state <= is_com ? HDR : IDLE;
						end
					end
					BODY_0: os_state <= is_body ? BODY_1 : (is_com ? HDR : IDLE);
					BODY_1: begin
						if (is_body) begin
							ts1_found <= !kind_ts2;
							ts2_found <= kind_ts2;
							os_state  <= IDLE;
						end else begin
							// a broken set may still be followed by a fresh COM
							os_state <= is_com ? HDR : IDLE;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/pipe_link_ctrl.sv */
////////////////////
// link control fsm: phy reset wait, polling training,
// idle exchange and U0 pass-through
// builds the transmit word stream toward the phy
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_link_ctrl
	import pipe_pkg::*;
(
	input  logic        local_clk,
	input  logic        ltssm_hot_reset_active,
	input  logic        phy_status,
	input  pwr_state_t  phy_power_down,
	input  lt_state_t   ltssm_state,
	input  logic        ltssm_training,
	input  logic        ltssm_train_active,
	input  logic        ltssm_train_config,
	input  logic        ltssm_train_idle,
	input  logic        ltssm_tx_elecidle,
	input  logic        idle_seen,
	input  pipe_word_t  link_out_data,
	input  pipe_kmask_t link_out_datak,
	input  logic        link_out_valid,
	output logic        ltssm_reset_n,
	output logic        ltssm_train_idle_pass,
	output logic        link_out_ready,
	output pipe_word_t  phy_tx_data,
	output pipe_kmask_t phy_tx_datak,
	output logic        phy_tx_elecidle
);

	pipe_state_t state;

	// word position inside the ordered set
	logic [1:0]  widx;
	logic        set_ts2;
	// symbols sent since the last skp
	logic [9:0]  skp_cnt;
	logic [2:0]  idle_cnt;

	pipe_word_t  local_data;
	pipe_kmask_t local_datak;
	logic        link_sel;
	logic        elecidle_local;
	logic        tx_elecidle_q;

	assign link_out_ready        = (state == U0);
	assign ltssm_train_idle_pass = (state == TRAIN_IDLE_1);
	assign link_sel              = link_out_ready && link_out_valid;
	assign phy_tx_elecidle       = tx_elecidle_q & ltssm_tx_elecidle;

	////////////////////
	// local word source
	////////////////////
	always_comb begin
		local_data  = IDLE_WORD;
		local_datak = 4'b0000;
		case (state)
			TRAIN_TS: begin
				case (widx)
					2'd0: begin
						local_data  = COM_WORD;
						local_datak = 4'b1111;
					end
					2'd1: local_data = set_ts2 ? TS2_HDR_WORD : TS1_HDR_WORD;
					default: local_data = set_ts2 ? TS2_ID_WORD : TS1_ID_WORD;
				endcase
			end
			TRAIN_SKP: begin
				local_data  = SKP_WORD;
				local_datak = 4'b1111;
			end
			default: ;
		endcase
	end

	// electrical idle is squashed whenever the link is driven
	always_comb begin
		case (state)
			TRAIN_TS, TRAIN_SKP, TRAIN_IDLE_0, TRAIN_IDLE_1, U0: elecidle_local = 1'b0;
			IDLE: elecidle_local = (phy_power_down != P0);
			default: elecidle_local = 1'b1;
		endcase
	end

	always_ff @(posedge local_clk) begin
		if (ltssm_hot_reset_active) begin
			tx_elecidle_q <= 1'b1;
		end else begin
			tx_elecidle_q <= elecidle_local;
		end
	end

	// transmit register, link words only in U0
	always_ff @(posedge local_clk) begin
		if (link_sel) begin
			phy_tx_data  <= link_out_data;
			phy_tx_datak <= link_out_datak;
		end else begin
			phy_tx_data  <= local_data;
			phy_tx_datak <= local_datak;
		end
	end

	////////////////////
	// main fsm
	////////////////////
	always_ff @(posedge local_clk) begin
		if (ltssm_hot_reset_active) begin
			state         <= RST_0;
			ltssm_reset_n <= 1'b0;
			widx          <= 2'd0;
			set_ts2       <= 1'b0;
			skp_cnt       <= '0;
			idle_cnt      <= '0;
		end else begin
			case (state)
				RST_0: state <= RST_1;
				// phy pulses status once its power-on reset is done
				RST_1: if (phy_status) state <= RST_2;
				RST_2: begin
					if (!phy_status) begin
						ltssm_reset_n <= 1'b1;
						state         <= RST_3;
					end
				end
				RST_3: state <= IDLE;
				IDLE: begin
					if (ltssm_training && (ltssm_train_active || ltssm_train_config)) begin
						widx    <= 2'd0;
						set_ts2 <= 1'b0;
						skp_cnt <= '0;
						state   <= TRAIN_TS;
					end
				end
				TRAIN_TS: begin
					widx <= widx + 2'd1;
					if (widx == 2'(OS_WORDS - 1)) begin
						skp_cnt <= skp_cnt + 10'(SKP_SYM_PER_OS);
						set_ts2 <= ltssm_train_config;
						if (ltssm_train_idle) begin
							idle_cnt <= '0;
							state    <= TRAIN_IDLE_0;
						end else if (!(ltssm_train_active || ltssm_train_config)) begin
							state <= IDLE;
						end else if (skp_cnt >= 10'(SKP_THRESHOLD)) begin
							state <= TRAIN_SKP;
						end
					end
				end
				TRAIN_SKP: begin
					skp_cnt <= skp_cnt - 10'(SKP_CREDIT);
					state   <= TRAIN_TS;
				end
				TRAIN_IDLE_0: begin
					if (idle_cnt < 3'(IDLE_SEND_WORDS)) idle_cnt <= idle_cnt + 3'd1;
					if (!ltssm_training) begin
						state <= IDLE;
					end else if (idle_cnt == 3'(IDLE_SEND_WORDS) && idle_seen) begin
						state <= TRAIN_IDLE_1;
					end
				end
				// hold pass until the ltssm drops its idle request
				TRAIN_IDLE_1: if (!ltssm_train_idle) state <= U0;
				U0: if (ltssm_state != LT_U0) state <= IDLE;
				default: state <= RST_0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/pipe_pkg.sv */
////////////////////
// shared definitions for the usb3 pipe control layer
// word and mask types, power and ltssm codes,
// ordered-set symbols, timing counts, main fsm states
////////////////////

`default_nettype none

package pipe_pkg;

	// one 32-bit word of four symbols and its k-symbol mask
	typedef logic [31:0] pipe_word_t;
	typedef logic [3:0]  pipe_kmask_t;

	// phy power states
	typedef logic [1:0] pwr_state_t;
	localparam pwr_state_t P0 = 2'd0;
	localparam pwr_state_t P1 = 2'd1;
	localparam pwr_state_t P2 = 2'd2;
	localparam pwr_state_t P3 = 2'd3;

	// ltssm state code, only U0 is decoded
	typedef logic [4:0] lt_state_t;
	localparam lt_state_t LT_U0 = 5'd16;

	////////////////////
	// ordered-set symbols
	////////////////////
	// COM is K28.5, SKP is K28.1
	localparam pipe_word_t COM_WORD     = 32'hBCBCBCBC;
	localparam pipe_word_t SKP_WORD     = 32'h3C3C3C3C;
	// D10.2 for TS1, D5.2 for TS2
	localparam pipe_word_t TS1_ID_WORD  = 32'h4A4A4A4A;
	localparam pipe_word_t TS2_ID_WORD  = 32'h45454545;
	// link functionality field left at zero
	localparam pipe_word_t TS1_HDR_WORD = 32'h00004A4A;
	localparam pipe_word_t TS2_HDR_WORD = 32'h00004545;
	localparam pipe_word_t IDLE_WORD    = 32'h00000000;

	////////////////////
	// counts
	////////////////////
	localparam int OS_WORDS          = 4;
	localparam int SKP_SYM_PER_OS    = 16;
	localparam int SKP_THRESHOLD     = 692;
	localparam int SKP_CREDIT        = 676;
	localparam int IDLE_SEND_WORDS   = 4;
	localparam int RXDET_DELAY       = 32;
	// roughly 8 ms at 250 MHz
	localparam int RXDET_TIMEOUT     = 2097152;
	localparam int RXDET_FAKE_LOOK   = 3;
	localparam int RXDET_FAKE_HOLD   = 8;
	localparam int RXDET_RESULT_HOLD = 3;

	localparam logic [2:0] RX_STATUS_DETECTED = 3'b011;

	// main link control fsm
	typedef enum logic [3:0] {
		RST_0,
		RST_1,
		RST_2,
		RST_3,
		IDLE,
		TRAIN_TS,
		TRAIN_SKP,
		TRAIN_IDLE_0,
		TRAIN_IDLE_1,
		U0
	} pipe_state_t;

endpackage

`default_nettype wire
